/* sim.f */
rtl/hdcpu_pkg.sv
rtl/console_control.sv
rtl/instr_decode.sv
rtl/hdcpu.sv
verification/hdcpu_tb.sv

/* verification/hdcpu_input.txt */
# test sw ir w c z ctrl, test in decimal, the rest in hex
# w bit 0 is W1, bit 1 is W2, bit 2 is W3; ctrl is the 27-bit control word
1 0 0 1 0 0 000082a
1 0 0 1 0 0 0001010
1 0 0 2 0 0 0000000
1 0 0 4 0 0 0000000
2 0 1 1 0 0 0001010
2 0 1 2 0 0 7906000
2 0 2 2 0 0 6606000
2 0 3 2 0 0 2b0e000
2 0 4 2 0 0 6006000
2 0 c 2 0 0 2e0e000
2 0 d 2 0 0 260e000
3 0 5 1 0 0 0001010
3 0 5 2 0 0 0a0c401
3 0 5 4 0 0 0002004
3 0 6 2 0 0 0f0c401
3 0 6 4 0 0 0a0c040
4 0 9 2 0 0 0f0c800
4 0 a 2 0 0 0a0c000
4 0 e 2 0 0 0000020
4 0 b 1 0 0 0001010
4 0 b 2 1 1 0000000
5 0 7 2 0 1 0000000
5 0 7 2 1 0 0000200
5 0 8 2 1 0 0000000
5 0 8 2 0 1 0000200
5 0 7 4 1 1 0000000
6 4 0 1 0 0 00920a8
6 4 0 2 0 0 00e20a8
6 4 0 1 0 0 00320a8
6 4 0 2 0 0 00420a8
6 4 0 1 0 0 00920a8
6 4 0 2 0 0 00e20a8
6 4 0 1 0 0 00320a8
7 3 0 1 0 0 00100a0
7 3 0 2 0 0 00b00a0
8 1 0 1 0 0 00004aa
8 1 0 1 0 0 00001ea
8 1 0 1 0 0 00001ea
8 1 0 2 0 0 0000000
9 3 0 1 0 0 00100a0
9 3 0 2 0 0 00b00a0
10 4 0 2 0 0 00e20a8
10 2 0 1 0 0 00004aa
10 2 0 1 0 0 00001a6
10 2 0 1 0 0 00001a6
11 5 0 1 0 0 0000000
11 7 0 2 0 0 0000000

/* verification/hdcpu_tb.sv */
`timescale 1ns/1ns

module hdcpu_tb;

    localparam int ctrl_bits = $bits(hdcpu_pkg::ctrl_word_t);
    localparam int reset_timeout = 20;
    localparam int run_timeout = 2000;

    logic t3;
    logic reset;
    hdcpu_pkg::sw_t sw;
    hdcpu_pkg::opcode_t ir;
    hdcpu_pkg::w_t w;
    logic c;
    logic z;
    hdcpu_pkg::ctrl_word_t ctrl;
    logic [ctrl_bits-1:0] ctrl_flat;

    int cycles = 0;
    int cur_test = -1;
    int test_checks = 0;
    int test_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    bit run_error = 0;

    hdcpu u_dut (
        .t3    (t3),
        .reset (reset),
        .sw    (sw),
        .ir    (ir),
        .w     (w),
        .c     (c),
        .z     (z),
        .ctrl  (ctrl)
    );

    assign ctrl_flat = ctrl;

    initial t3 = 1'b0;
    always #5 t3 = ~t3;

    // Reset covers the first four rising edges
    initial begin
        reset = 1'b1;
        repeat (4) @(negedge t3);
        reset = 1'b0;
    end

    task automatic drive_inputs(input logic [2:0] sw_v, input logic [3:0] ir_v,
                                input logic [2:0] w_v, input logic c_v, input logic z_v);
        @(negedge t3);
        sw = sw_v;
        ir = ir_v;
        w = w_v;
        c = c_v;
        z = z_v;
        cycles++;
    endtask

    // Sample 1 ns before the rising edge
    task automatic check_ctrl(input int test_num, input logic [ctrl_bits-1:0] expected);
        #4;
        test_checks++;
        assert (ctrl_flat === expected) else begin
            $display("ERR %0t test %0d expected %h actual %h",
                     $time, test_num, expected, ctrl_flat);
            test_errors++;
        end
    endtask

    task automatic idle_beats(input int count);
        repeat (count) begin
            drive_inputs(sw, ir, 3'b000, c, z); // Idle beat leaves ST0 alone
            check_ctrl(cur_test, '0);
        end
    endtask

    task automatic finish_test(input int test_num);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d passed, %0d checks", test_num, test_checks);
        end else begin
            tests_failed++;
            $display("test %0d failed, %0d of %0d checks wrong",
                     test_num, test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        int fd;
        int n;
        int f_test;
        int wait_cycles;
        string line;
        logic [31:0] f_sw;
        logic [31:0] f_ir;
        logic [31:0] f_w;
        logic [31:0] f_c;
        logic [31:0] f_z;
        logic [31:0] f_exp;

        sw = hdcpu_pkg::mode_run;
        ir = '0;
        w = '0;
        c = 1'b0;
        z = 1'b0;
        void'($urandom(32'hdc7ed271));

        // Words that would be busy outside reset
        cur_test = 0;
        drive_inputs(hdcpu_pkg::mode_mem_wr, hdcpu_pkg::op_add, 3'b001, 1'b1, 1'b1);
        check_ctrl(0, '0);
        drive_inputs(hdcpu_pkg::mode_run, hdcpu_pkg::op_stp, 3'b001, 1'b1, 1'b1);
        check_ctrl(0, '0);
        drive_inputs(hdcpu_pkg::mode_reg_wr, hdcpu_pkg::op_ld, 3'b010, 1'b1, 1'b1);
        check_ctrl(0, '0);
        drive_inputs(hdcpu_pkg::mode_run, '0, 3'b000, 1'b0, 1'b0);

        wait_cycles = 0;
        while (reset === 1'b1 && wait_cycles < reset_timeout) begin
            @(posedge t3);
            wait_cycles++;
        end
        finish_test(0);

        if (reset !== 1'b0) begin
            $display("Reset was never released within %0d cycles", reset_timeout);
            run_error = 1;
        end else begin
            fd = $fopen("verification/hdcpu_input.txt", "r");
            if (fd == 0) begin
                $display("Could not open the stimulus file verification/hdcpu_input.txt");
                run_error = 1;
            end else begin
                while (!$feof(fd) && cycles < run_timeout) begin
                    line = "";
                    n = $fgets(line, fd);
                    if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
                        continue;
                    end
                    n = $sscanf(line, "%d %h %h %h %h %h %h",
                                f_test, f_sw, f_ir, f_w, f_c, f_z, f_exp);
                    if (n != 7) begin
                        $display("Stimulus line could not be parsed: %s", line);
                        run_error = 1;
                        continue;
                    end
                    if (f_test != cur_test) begin
                        if (test_checks > 0) begin
                            finish_test(cur_test);
                        end
                        cur_test = f_test;
                        idle_beats($urandom_range(3));
                    end
                    drive_inputs(f_sw[2:0], f_ir[3:0], f_w[2:0], f_c[0], f_z[0]);
                    check_ctrl(cur_test, f_exp[ctrl_bits-1:0]);
                end
                if (!$feof(fd)) begin
                    $display("Stimulus did not finish within %0d cycles", run_timeout);
                    run_error = 1;
                end
                finish_test(cur_test);
                $fclose(fd);
            end
        end

        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && !run_error) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* rtl/hdcpu.sv */
`timescale 1ns/1ns

module hdcpu (
    input  logic                   t3,
    input  logic                   reset,
    input  hdcpu_pkg::sw_t         sw,
    input  hdcpu_pkg::opcode_t     ir,
    input  hdcpu_pkg::w_t          w,
    input  logic                   c,
    input  logic                   z,
    output hdcpu_pkg::ctrl_word_t  ctrl
);

    hdcpu_pkg::ctrl_word_t console_word;
    hdcpu_pkg::ctrl_word_t run_word;
    logic                  run_active;

    console_control u_console (
        .t3           (t3),
        .reset        (reset),
        .sw           (sw),
        .w            (w),
        .console_word (console_word),
        .run_active   (run_active)
    );

    // Execute decoding selected once the PC is loaded
    instr_decode u_instr (
        .ir       (ir),
        .w        (w),
        .c        (c),
        .z        (z),
        .run_word (run_word)
    );

    always_comb begin
        if (reset) begin
            ctrl = '0; // Datapath stays idle in reset
        end else if (run_active) begin
            ctrl = run_word;
        end else begin
            ctrl = console_word;
        end
    end

endmodule

/* rtl/instr_decode.sv */
`timescale 1ns/1ns

module instr_decode (
    input  hdcpu_pkg::opcode_t     ir,
    input  hdcpu_pkg::w_t          w,
    input  logic                   c,
    input  logic                   z,
    output hdcpu_pkg::ctrl_word_t  run_word
);

    logic w1;
    logic w2;
    logic w3;
    logic take_branch;
    hdcpu_pkg::alu_fn_t op_fn;

    assign w1 = w[0];
    assign w2 = w[1];
    assign w3 = w[2];

    assign take_branch = ((ir == hdcpu_pkg::op_jc) && c) ||
                         ((ir == hdcpu_pkg::op_jz) && z);

    // S code for the register to register group
    always_comb begin
        case (ir)
            hdcpu_pkg::op_add: op_fn = hdcpu_pkg::alu_add;
            hdcpu_pkg::op_sub: op_fn = hdcpu_pkg::alu_sub;
            hdcpu_pkg::op_inc: op_fn = hdcpu_pkg::alu_inc;
            hdcpu_pkg::op_and: op_fn = hdcpu_pkg::alu_and;
            hdcpu_pkg::op_or:  op_fn = hdcpu_pkg::alu_or;
            hdcpu_pkg::op_xor: op_fn = hdcpu_pkg::alu_xor;
            default:           op_fn = '0;
        endcase
    end

    always_comb begin
        run_word = '0;

        // Fetch overlaps the first beat of every instruction
        run_word.lir = w1;
        run_word.pcinc = w1;

        case (ir)
            hdcpu_pkg::op_add,
            hdcpu_pkg::op_sub,
            hdcpu_pkg::op_inc: begin
                if (w2) begin
                    run_word.s = op_fn;
                    run_word.cin = (ir == hdcpu_pkg::op_add);
                    run_word.abus = 1'b1;
                    run_word.drw = 1'b1;
                    run_word.ldz = 1'b1;
                    run_word.ldc = 1'b1;
                end
            end

            hdcpu_pkg::op_and,
            hdcpu_pkg::op_or,
            hdcpu_pkg::op_xor: begin
                if (w2) begin
                    run_word.s = op_fn;
                    run_word.m = 1'b1; // Logic ops leave carry alone
                    run_word.abus = 1'b1;
                    run_word.drw = 1'b1;
                    run_word.ldz = 1'b1;
                end
            end

            hdcpu_pkg::op_ld: begin
                if (w2) begin
                    run_word.m = 1'b1;
                    run_word.s = hdcpu_pkg::alu_pass_a;
                    run_word.abus = 1'b1;
                    run_word.lar = 1'b1;
                    run_word.long_cyc = 1'b1;
                end
                if (w3) begin
                    run_word.drw = 1'b1;
                    run_word.mbus = 1'b1;
                end
            end

            hdcpu_pkg::op_st: begin
                // Address from B on W2 and data from A on W3
                if (w2) begin
                    run_word.m = 1'b1;
                    run_word.s = hdcpu_pkg::alu_pass_b;
                    run_word.abus = 1'b1;
                    run_word.lar = 1'b1;
                    run_word.long_cyc = 1'b1;
                end
                if (w3) begin
                    run_word.m = 1'b1;
                    run_word.s = hdcpu_pkg::alu_pass_a;
                    run_word.abus = 1'b1;
                    run_word.memw = 1'b1;
                end
            end

            hdcpu_pkg::op_jc,
            hdcpu_pkg::op_jz: begin
                run_word.pcadd = w2 && take_branch;
            end

            hdcpu_pkg::op_jmp: begin
                if (w2) begin
                    run_word.m = 1'b1;
                    run_word.s = hdcpu_pkg::alu_pass_b;
                    run_word.abus = 1'b1;
                    run_word.lpc = 1'b1;
                end
            end

            hdcpu_pkg::op_out: begin
                if (w2) begin
                    run_word.m = 1'b1;
                    run_word.s = hdcpu_pkg::alu_pass_a;
                    run_word.abus = 1'b1;
                end
            end

            hdcpu_pkg::op_stp: begin
                run_word.stop = w2;
            end

            default: begin
                // Fetch fields only
            end
        endcase
    end

endmodule

/* rtl/console_control.sv */
`timescale 1ns/1ns

module console_control (
    input  logic                   t3,
    input  logic                   reset,
    input  hdcpu_pkg::sw_t         sw,
    input  hdcpu_pkg::w_t          w,
    output hdcpu_pkg::ctrl_word_t  console_word,
    output logic                   run_active
);

    logic st0;      // Start flag for the second phase of a console operation
    logic set_req;
    logic clr_req;
    logic w1;
    logic w2;
    logic reg_beat;

    assign w1 = w[0];
    assign w2 = w[1];
    assign reg_beat = w1 | w2;

    // Register write finishes on the second W2
    assign clr_req = (sw == hdcpu_pkg::mode_reg_wr) && st0 && w2;

    assign run_active = (sw == hdcpu_pkg::mode_run) && st0;

    always_ff @(posedge t3) begin
        if (reset) begin
            st0 <= 1'b0;
        end else if (set_req) begin
            st0 <= 1'b1;
        end else if (clr_req) begin
            st0 <= 1'b0;
        end
    end

    always_comb begin
        console_word = '0;
        set_req = 1'b0;
        case (sw)
            hdcpu_pkg::mode_mem_wr: begin
                if (w1) begin
                    console_word.sbus = 1'b1;
                    console_word.stop = 1'b1;
                    console_word.short_cyc = 1'b1;
                    console_word.selctl = 1'b1;
                    if (!st0) begin
                        console_word.lar = 1'b1; // Address from switches
                        set_req = 1'b1;
                    end else begin
                        console_word.memw = 1'b1;
                        console_word.arinc = 1'b1;
                    end
                end
            end

            hdcpu_pkg::mode_mem_rd: begin
                if (w1) begin
                    console_word.stop = 1'b1;
                    console_word.short_cyc = 1'b1;
                    console_word.selctl = 1'b1;
                    if (!st0) begin
                        console_word.sbus = 1'b1;
                        console_word.lar = 1'b1;
                        set_req = 1'b1;
                    end else begin
                        console_word.mbus = 1'b1;
                        console_word.arinc = 1'b1;
                    end
                end
            end

            hdcpu_pkg::mode_reg_rd: begin
                // R0,R1 on W1 then R2,R3 on W2
                console_word.selctl = reg_beat;
                console_word.stop = reg_beat;
                console_word.sel = {w2, 1'b0, w2, reg_beat};
            end

            hdcpu_pkg::mode_reg_wr: begin
                if (reg_beat) begin
                    console_word.sbus = 1'b1;
                    console_word.selctl = 1'b1;
                    console_word.drw = 1'b1;
                    console_word.stop = 1'b1;
                    console_word.sel[3] = st0;
                    console_word.sel[2] = w2;
                    console_word.sel[1] = (!st0 && w1) || (st0 && w2);
                    console_word.sel[0] = w1;
                end
                set_req = !st0 && w2; // Upper register pair next
            end

            hdcpu_pkg::mode_run: begin
                // First beat loads the PC and fetch starts after
                if (!st0 && w1) begin
                    console_word.lpc = 1'b1;
                    console_word.sbus = 1'b1;
                    console_word.short_cyc = 1'b1;
                    console_word.stop = 1'b1;
                    set_req = 1'b1;
                end
            end
        endcase
    end

endmodule

/* rtl/hdcpu_pkg.sv */
package hdcpu_pkg;

    // Beat levels from the timing generator with W1 in bit 0
    typedef logic [2:0] w_t;

    // Console switch setting
    typedef logic [2:0] sw_t;

    // High nibble of the instruction register
    typedef logic [3:0] opcode_t;

    // ALU S code
    typedef logic [3:0] alu_fn_t;

    localparam sw_t mode_run    = 3'b000;
    localparam sw_t mode_mem_wr = 3'b001;
    localparam sw_t mode_mem_rd = 3'b010;
    localparam sw_t mode_reg_rd = 3'b011;
    localparam sw_t mode_reg_wr = 3'b100;

    localparam opcode_t op_add = 4'b0001;
    localparam opcode_t op_sub = 4'b0010;
    localparam opcode_t op_and = 4'b0011;
    localparam opcode_t op_inc = 4'b0100;
    localparam opcode_t op_ld  = 4'b0101;
    localparam opcode_t op_st  = 4'b0110;
    localparam opcode_t op_jc  = 4'b0111;
    localparam opcode_t op_jz  = 4'b1000;
    localparam opcode_t op_jmp = 4'b1001;
    localparam opcode_t op_out = 4'b1010;
    localparam opcode_t op_or  = 4'b1100;
    localparam opcode_t op_xor = 4'b1101;
    localparam opcode_t op_stp = 4'b1110;

    // S codes as the ALU chip expects them
    localparam alu_fn_t alu_add    = 4'b1001;
    localparam alu_fn_t alu_sub    = 4'b0110;
    localparam alu_fn_t alu_and    = 4'b1011;
    localparam alu_fn_t alu_inc    = 4'b0000;
    localparam alu_fn_t alu_or     = 4'b1110;
    localparam alu_fn_t alu_xor    = 4'b0110; // Same code as sub but with M set
    localparam alu_fn_t alu_pass_a = 4'b1010;
    localparam alu_fn_t alu_pass_b = 4'b1111;

    // One control word for the datapath with the first field as MSB
    typedef struct packed {
        logic    ldc;       // Load carry flag
        logic    ldz;       // Load zero flag
        logic    cin;       // ALU carry in
        alu_fn_t s;
        logic [3:0] sel;    // Destination pair high and source pair low
        logic    m;         // ALU logic mode
        logic    abus;      // ALU onto data bus
        logic    drw;       // Register file write
        logic    pcinc;
        logic    lpc;       // Load PC from bus
        logic    lar;       // Load address register
        logic    pcadd;     // PC plus IR offset
        logic    arinc;
        logic    selctl;    // Register select from sel, not IR
        logic    memw;
        logic    stop;      // Halt after this beat
        logic    lir;
        logic    sbus;      // Switches onto data bus
        logic    mbus;      // Memory onto data bus
        logic    short_cyc; // Only W1 this cycle
        logic    long_cyc;  // Add W3 this cycle
    } ctrl_word_t;

endpackage
